/* common/clkPkg.sv */
`default_nettype none

package clkPkg;

  // Diagnostic bus widths
  localparam int SEL_W = 3;
  localparam int NIB_W = 4;
  localparam int READ_W = 6;

  // Clock-control state widths
  localparam int BURST_W = 8;
  localparam int RATE_W = 2;
  localparam int RATE_CNT_W = 3;

  // EBUS reset timing, prescaler wraps every 4 cycles
  localparam int PRESCALE_W = 2;
  localparam int RESET_CNT_W = 4;
  localparam logic [RESET_CNT_W-1:0] RESET_LOAD = '1;

  // Control group, codes 3 and 4 are decoded but do nothing here
  typedef enum logic [SEL_W-1:0] {
    FN_NONE        = 3'd0,
    FN_START       = 3'd1,
    FN_SINGLE_STEP = 3'd2,
    FN_EBOX_SS     = 3'd3,
    FN_COND_SS     = 3'd4,
    FN_BURST       = 3'd5,
    FN_CLR_RESET   = 3'd6,
    FN_SET_RESET   = 3'd7
  } ctlFunc_e;

  // Load group, codes 0 and 1 are unused
  typedef enum logic [SEL_W-1:0] {
    LD_BURST_LO  = 3'd2,
    LD_BURST_HI  = 3'd3,
    LD_SRC_RATE  = 3'd4,
    LD_EBOX_DIS  = 3'd5,
    LD_PAR_CHECK = 3'd6,
    LD_MBOX_CTL  = 3'd7
  } ldFunc_e;

  // Readback field select
  typedef enum logic [SEL_W-1:0] {
    RD_RUN     = 3'd0,
    RD_RESET   = 3'd1,
    RD_CONFIG  = 3'd2,
    RD_DISABLE = 3'd3
  } readSel_e;

endpackage

`default_nettype wire

/* logic/functionDecoder.sv */
`timescale 1ns/10ps
`default_nettype none

module functionDecoder (
  input  wire                         MAIN_SOURCE,
  input  wire                         CLK,
  input  wire                         ctlFunc,
  input  wire                         ldFunc,
  input  wire [clkPkg::SEL_W-1:0]     diagSel,
  output logic                        fnStart,
  output logic                        fnStep,
  output logic                        fnBurst,
  output logic                        ldBurstLo,
  output logic                        ldBurstHi,
  output logic                        ldSrcRate,
  output logic                        ldEboxDis,
  output logic                        ldMboxCtl,
  output logic                        mrReset
);

  clkPkg::ctlFunc_e ctlCode;
  clkPkg::ldFunc_e  ldCode;
  logic             fnClrReset;
  logic             fnSetReset;

  assign ctlCode = clkPkg::ctlFunc_e'(diagSel);
  assign ldCode = clkPkg::ldFunc_e'(diagSel);

  // Control group pulses
  always_comb begin
    {fnStart, fnStep, fnBurst, fnClrReset, fnSetReset} = '0;
    if (ctlFunc) begin
      case (ctlCode)
        clkPkg::FN_START:       fnStart = 1'b1;
        clkPkg::FN_SINGLE_STEP: fnStep = 1'b1;
        clkPkg::FN_BURST:       fnBurst = 1'b1;
        clkPkg::FN_CLR_RESET:   fnClrReset = 1'b1;
        clkPkg::FN_SET_RESET:   fnSetReset = 1'b1;
        // EBOX SS and cond SS fall through as no-ops
        default: ;
      endcase
    end
  end

  // Load group pulses, parity check load is ignored
  always_comb begin
    {ldBurstLo, ldBurstHi, ldSrcRate, ldEboxDis, ldMboxCtl} = '0;
    if (ldFunc) begin
      case (ldCode)
        clkPkg::LD_BURST_LO: ldBurstLo = 1'b1;
        clkPkg::LD_BURST_HI: ldBurstHi = 1'b1;
        clkPkg::LD_SRC_RATE: ldSrcRate = 1'b1;
        clkPkg::LD_EBOX_DIS: ldEboxDis = 1'b1;
        clkPkg::LD_MBOX_CTL: ldMboxCtl = 1'b1;
        default: ;
      endcase
    end
  end

  // Master reset, set wins over clear
  always_ff @(posedge MAIN_SOURCE or posedge CLK) begin
    if (CLK) begin
      mrReset <= 1'b1;
    end else if (fnSetReset) begin
      mrReset <= 1'b1;
    end else if (fnClrReset) begin
      mrReset <= 1'b0;
    end
  end

  // At most one function fires per strobe cycle
  assert property (@(posedge MAIN_SOURCE) disable iff (CLK)
    $onehot0({fnStart, fnStep, fnBurst, fnClrReset, fnSetReset,
              ldBurstLo, ldBurstHi, ldSrcRate, ldEboxDis, ldMboxCtl}));

endmodule

`default_nettype wire

/* logic/configRegs.sv */
`timescale 1ns/10ps
`default_nettype none

module configRegs (
  input  wire                         MAIN_SOURCE,
  input  wire                         CLK,
  input  wire                         ldSrcRate,
  input  wire                         ldEboxDis,
  input  wire                         ldMboxCtl,
  input  wire [clkPkg::NIB_W-1:0]     ebusData,
  output logic [clkPkg::RATE_W-1:0]   sourceSel,
  output logic [clkPkg::RATE_W-1:0]   rateSel,
  output logic                        crmDis,
  output logic                        edpDis,
  output logic                        ctlDis,
  output logic                        mboxCycleDis,
  output logic                        errStopEn
);

  // Source select high pair, rate select low pair
  always_ff @(posedge MAIN_SOURCE or posedge CLK) begin
    if (CLK) begin
      sourceSel <= '0;
      rateSel <= '0;
    end else if (ldSrcRate) begin
      sourceSel <= ebusData[3:2];
      rateSel <= ebusData[1:0];
    end
  end

  // EBOX clock disables come from data bits 2 to 0
  always_ff @(posedge MAIN_SOURCE or posedge CLK) begin
    if (CLK) begin
      crmDis <= 1'b0;
      edpDis <= 1'b0;
      ctlDis <= 1'b0;
    end else if (ldEboxDis) begin
      crmDis <= ebusData[2];
      edpDis <= ebusData[1];
      ctlDis <= ebusData[0];
    end
  end

  // MBOX control uses only the outer data bits
  always_ff @(posedge MAIN_SOURCE or posedge CLK) begin
    if (CLK) begin
      mboxCycleDis <= 1'b0;
      errStopEn <= 1'b0;
    end else if (ldMboxCtl) begin
      mboxCycleDis <= ebusData[3];
      errStopEn <= ebusData[0];
    end
  end

endmodule

`default_nettype wire

/* gating/burstCounter.sv */
`timescale 1ns/10ps
`default_nettype none

module burstCounter (
  input  wire                         MAIN_SOURCE,
  input  wire                         CLK,
  input  wire                         ldBurstLo,
  input  wire                         ldBurstHi,
  input  wire [clkPkg::NIB_W-1:0]     ebusData,
  input  wire                         burstTick,
  output logic [clkPkg::BURST_W-1:0]  burstCount,
  output logic                        burstZero
);

  // Nibble loads take priority over the tick
  always_ff @(posedge MAIN_SOURCE or posedge CLK) begin
    if (CLK) begin
      burstCount <= '0;
    end else if (ldBurstLo) begin
      burstCount[3:0] <= ebusData;
    end else if (ldBurstHi) begin
      burstCount[7:4] <= ebusData;
    end else if (burstTick) begin
      burstCount <= burstCount - 1'b1;
    end
  end

  assign burstZero = burstCount == '0;

  // Gate must stop before the count would wrap
  assert property (@(posedge MAIN_SOURCE) disable iff (CLK)
    burstTick |-> !burstZero);

endmodule

`default_nettype wire

/* gating/clockGate.sv */
`timescale 1ns/10ps
`default_nettype none

module clockGate (
  input  wire                         MAIN_SOURCE,
  input  wire                         CLK,
  input  wire                         fnStart,
  input  wire                         fnStep,
  input  wire                         fnBurst,
  input  wire [clkPkg::RATE_W-1:0]    rateSel,
  input  wire                         burstZero,
  output logic                        eboxClkEn,
  output logic                        burstTick,
  output logic                        running,
  output logic                        stepPending
);

  logic [clkPkg::RATE_CNT_W-1:0] rateCnt;
  logic [clkPkg::RATE_CNT_W-1:0] rateMask;
  logic                          rateStrobe;
  logic                          burstMode;

  // Free-running divider
  always_ff @(posedge MAIN_SOURCE or posedge CLK) begin
    if (CLK) begin
      rateCnt <= '0;
    end else begin
      rateCnt <= rateCnt + 1'b1;
    end
  end

  // Strobe once every 2^rateSel cycles
  assign rateMask = clkPkg::RATE_CNT_W'((1 << rateSel) - 1);
  assign rateStrobe = (rateCnt & rateMask) == '0;

  // Tick when any mode asks for one
  assign eboxClkEn = rateStrobe & (running | stepPending | (burstMode & ~burstZero));
  assign burstTick = eboxClkEn & burstMode;

  // Run modes are kept mutually exclusive
  always_ff @(posedge MAIN_SOURCE or posedge CLK) begin
    if (CLK) begin
      running <= 1'b0;
      stepPending <= 1'b0;
      burstMode <= 1'b0;
    end else if (fnStart) begin
      running <= 1'b1;
      stepPending <= 1'b0;
      burstMode <= 1'b0;
    end else if (fnStep) begin
      running <= 1'b0;
      stepPending <= 1'b1;
      burstMode <= 1'b0;
    end else if (fnBurst) begin
      running <= 1'b0;
      stepPending <= 1'b0;
      burstMode <= 1'b1;
    end else begin
      // Step is consumed by its one tick
      if (stepPending && eboxClkEn) begin
        stepPending <= 1'b0;
      end
      // Burst stops itself once the count runs out
      if (burstMode && burstZero) begin
        burstMode <= 1'b0;
      end
    end
  end

  // Below full rate, ticks are never back to back
  assert property (@(posedge MAIN_SOURCE) disable iff (CLK)
    eboxClkEn ##1 (rateSel != '0 && $stable(rateSel)) |-> !eboxClkEn);

endmodule

`default_nettype wire

/* logic/ebusResetTimer.sv */
`timescale 1ns/10ps
`default_nettype none

module ebusResetTimer (
  input  wire   MAIN_SOURCE,
  input  wire   CLK,
  input  wire   conoReset,
  output logic  ebusReset
);

  logic [clkPkg::PRESCALE_W-1:0]  prescale;
  logic [clkPkg::RESET_CNT_W-1:0] resetCnt;
  logic                           prescaleTick;

  // Free-running prescaler
  always_ff @(posedge MAIN_SOURCE or posedge CLK) begin
    if (CLK) begin
      prescale <= '0;
    end else begin
      prescale <= prescale + 1'b1;
    end
  end

  assign prescaleTick = prescale == '1;

  // Countdown holds at zero until reloaded
  always_ff @(posedge MAIN_SOURCE or posedge CLK) begin
    if (CLK) begin
      resetCnt <= clkPkg::RESET_LOAD;
    end else if (conoReset) begin
      resetCnt <= clkPkg::RESET_LOAD;
    end else if (prescaleTick && resetCnt != '0) begin
      resetCnt <= resetCnt - 1'b1;
    end
  end

  assign ebusReset = resetCnt != '0;

endmodule

`default_nettype wire

/* logic/diagReadMux.sv */
`timescale 1ns/10ps
`default_nettype none

module diagReadMux (
  input  wire                         diagRead,
  input  wire [clkPkg::SEL_W-1:0]     diagSel,
  input  wire                         running,
  input  wire                         stepPending,
  input  wire                         burstZero,
  input  wire [clkPkg::BURST_W-1:0]   burstCount,
  input  wire                         mrReset,
  input  wire                         ebusReset,
  input  wire [clkPkg::RATE_W-1:0]    sourceSel,
  input  wire [clkPkg::RATE_W-1:0]    rateSel,
  input  wire                         errStopEn,
  input  wire                         mboxCycleDis,
  input  wire                         crmDis,
  input  wire                         edpDis,
  input  wire                         ctlDis,
  output logic                        ebusDriving,
  output logic [clkPkg::READ_W-1:0]   readData
);

  clkPkg::readSel_e readSel;

  assign readSel = clkPkg::readSel_e'(diagSel);
  assign ebusDriving = diagRead;

  // Field select, msb first
  always_comb begin
    readData = '0;
    if (diagRead) begin
      case (readSel)
        clkPkg::RD_RUN:     readData = {running, burstZero, burstCount[7:4]};
        clkPkg::RD_RESET:   readData = {mrReset, ebusReset, burstCount[3:0]};
        clkPkg::RD_CONFIG:  readData = {sourceSel, rateSel, errStopEn, mboxCycleDis};
        clkPkg::RD_DISABLE: readData = {crmDis, edpDis, ctlDis, stepPending, 2'b00};
        default:            readData = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/clkControl.sv */
`timescale 1ns/10ps
`default_nettype none

module clkControl (
  input  wire                         MAIN_SOURCE,
  input  wire                         CLK,
  input  wire                         ctlFunc,
  input  wire                         ldFunc,
  input  wire [clkPkg::SEL_W-1:0]     diagSel,
  input  wire [clkPkg::NIB_W-1:0]     ebusData,
  input  wire                         diagRead,
  input  wire                         conoReset,
  output logic                        eboxClkEn,
  output logic                        mrReset,
  output logic                        ebusReset,
  output logic [clkPkg::RATE_W-1:0]   sourceSel,
  output logic [clkPkg::RATE_W-1:0]   rateSel,
  output logic                        crmDis,
  output logic                        edpDis,
  output logic                        ctlDis,
  output logic                        mboxCycleDis,
  output logic                        errStopEn,
  output logic                        ebusDriving,
  output logic [clkPkg::READ_W-1:0]   readData
);

  // Decoded function pulses
  logic fnStart;
  logic fnStep;
  logic fnBurst;
  logic ldBurstLo;
  logic ldBurstHi;
  logic ldSrcRate;
  logic ldEboxDis;
  logic ldMboxCtl;

  // Gate and burst status
  logic                       burstTick;
  logic                       burstZero;
  logic                       running;
  logic                       stepPending;
  logic [clkPkg::BURST_W-1:0] burstCount;

  functionDecoder functionDecoder_i (
    .MAIN_SOURCE (MAIN_SOURCE),
    .CLK         (CLK),
    .ctlFunc     (ctlFunc),
    .ldFunc      (ldFunc),
    .diagSel     (diagSel),
    .fnStart     (fnStart),
    .fnStep      (fnStep),
    .fnBurst     (fnBurst),
    .ldBurstLo   (ldBurstLo),
    .ldBurstHi   (ldBurstHi),
    .ldSrcRate   (ldSrcRate),
    .ldEboxDis   (ldEboxDis),
    .ldMboxCtl   (ldMboxCtl),
    .mrReset     (mrReset)
  );

  configRegs configRegs_i (
    .MAIN_SOURCE  (MAIN_SOURCE),
    .CLK          (CLK),
    .ldSrcRate    (ldSrcRate),
    .ldEboxDis    (ldEboxDis),
    .ldMboxCtl    (ldMboxCtl),
    .ebusData     (ebusData),
    .sourceSel    (sourceSel),
    .rateSel      (rateSel),
    .crmDis       (crmDis),
    .edpDis       (edpDis),
    .ctlDis       (ctlDis),
    .mboxCycleDis (mboxCycleDis),
    .errStopEn    (errStopEn)
  );

  clockGate clockGate_i (
    .MAIN_SOURCE (MAIN_SOURCE),
    .CLK         (CLK),
    .fnStart     (fnStart),
    .fnStep      (fnStep),
    .fnBurst     (fnBurst),
    .rateSel     (rateSel),
    .burstZero   (burstZero),
    .eboxClkEn   (eboxClkEn),
    .burstTick   (burstTick),
    .running     (running),
    .stepPending (stepPending)
  );

  burstCounter burstCounter_i (
    .MAIN_SOURCE (MAIN_SOURCE),
    .CLK         (CLK),
    .ldBurstLo   (ldBurstLo),
    .ldBurstHi   (ldBurstHi),
    .ebusData    (ebusData),
    .burstTick   (burstTick),
    .burstCount  (burstCount),
    .burstZero   (burstZero)
  );

  ebusResetTimer ebusResetTimer_i (
    .MAIN_SOURCE (MAIN_SOURCE),
    .CLK         (CLK),
    .conoReset   (conoReset),
    .ebusReset   (ebusReset)
  );

  // Readback sees every block
  diagReadMux diagReadMux_i (
    .diagRead     (diagRead),
    .diagSel      (diagSel),
    .running      (running),
    .stepPending  (stepPending),
    .burstZero    (burstZero),
    .burstCount   (burstCount),
    .mrReset      (mrReset),
    .ebusReset    (ebusReset),
    .sourceSel    (sourceSel),
    .rateSel      (rateSel),
    .errStopEn    (errStopEn),
    .mboxCycleDis (mboxCycleDis),
    .crmDis       (crmDis),
    .edpDis       (edpDis),
    .ctlDis       (ctlDis),
    .ebusDriving  (ebusDriving),
    .readData     (readData)
  );

endmodule

`default_nettype wire

/* bench/clkControlChecks.svh */
`ifndef CLK_CONTROL_CHECKS_SVH
`define CLK_CONTROL_CHECKS_SVH

// First error ends the run
task automatic abortRun(input string why);
  $display("%s", why);
  $display("STATUS: FAIL");
  $fatal(1, "simulation stopped on first error");
endtask

// Readback field compare
task automatic checkRead(input string name,
                         input logic [clkPkg::READ_W-1:0] actual,
                         input logic [clkPkg::READ_W-1:0] expected);
  if (actual !== expected) begin
    abortRun($sformatf("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, actual, expected));
  end
endtask

// Single-bit output or status compare
task automatic checkLevel(input string name, input logic actual, input logic expected);
  if (actual !== expected) begin
    abortRun($sformatf("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, actual, expected));
  end
endtask

// Pulse counts and gaps, burst-count wide
task automatic checkCount(input string name,
                          input logic [clkPkg::BURST_W-1:0] actual,
                          input logic [clkPkg::BURST_W-1:0] expected);
  if (actual !== expected) begin
    abortRun($sformatf("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, actual, expected));
  end
endtask

`endif

/* bench/clkControlTb.sv */
`timescale 1ns/10ps
`default_nettype none

module clkControlTb;

  localparam int HALF_PERIOD = 2;
  localparam int RESET_CYCLES = 8;
  localparam int SAMPLE_DLY = 1;
  localparam int PULSE_TIMEOUT = 16;
  localparam int STEP_WINDOW = 20;
  localparam int EBUS_RESET_TIMEOUT = 100;
  localparam int BURST_TIMEOUT = 2100;
  localparam int SEED = 1574;

  // What a table row does
  typedef enum logic [2:0] {
    ROW_CTL, ROW_LD, ROW_READ, ROW_STEP, ROW_RUN, ROW_BURST, ROW_CONO
  } rowKind_e;

  typedef struct packed {
    rowKind_e                   kind;
    logic [clkPkg::SEL_W-1:0]   sel;
    logic [clkPkg::NIB_W-1:0]   data;
    logic [clkPkg::BURST_W-1:0] expVal;
  } row_t;

  logic                        MAIN_SOURCE;
  logic                        CLK;
  logic                        ctlFunc;
  logic                        ldFunc;
  logic [clkPkg::SEL_W-1:0]    diagSel;
  logic [clkPkg::NIB_W-1:0]    ebusData;
  logic                        diagRead;
  logic                        conoReset;
  logic                        eboxClkEn;
  logic                        mrReset;
  logic                        ebusReset;
  logic [clkPkg::RATE_W-1:0]   sourceSel;
  logic [clkPkg::RATE_W-1:0]   rateSel;
  logic                        crmDis;
  logic                        edpDis;
  logic                        ctlDis;
  logic                        mboxCycleDis;
  logic                        errStopEn;
  logic                        ebusDriving;
  logic [clkPkg::READ_W-1:0]   readData;

  // Expected register state tracked from each load
  logic                        expMr;
  logic [clkPkg::RATE_W-1:0]   expSrc;
  logic [clkPkg::RATE_W-1:0]   expRate;
  logic                        expCrm;
  logic                        expEdp;
  logic                        expCtl;
  logic                        expMbox;
  logic                        expErr;

  row_t                        rows[$];
  int unsigned                 seedVal;
  logic [clkPkg::BURST_W-1:0]  burstLen;

  clkControl dut_i (
    .MAIN_SOURCE  (MAIN_SOURCE),
    .CLK          (CLK),
    .ctlFunc      (ctlFunc),
    .ldFunc       (ldFunc),
    .diagSel      (diagSel),
    .ebusData     (ebusData),
    .diagRead     (diagRead),
    .conoReset    (conoReset),
    .eboxClkEn    (eboxClkEn),
    .mrReset      (mrReset),
    .ebusReset    (ebusReset),
    .sourceSel    (sourceSel),
    .rateSel      (rateSel),
    .crmDis       (crmDis),
    .edpDis       (edpDis),
    .ctlDis       (ctlDis),
    .mboxCycleDis (mboxCycleDis),
    .errStopEn    (errStopEn),
    .ebusDriving  (ebusDriving),
    .readData     (readData)
  );

  `include "clkControlChecks.svh"

  initial begin
    MAIN_SOURCE = 1'b0;
    forever #(HALF_PERIOD) MAIN_SOURCE = ~MAIN_SOURCE;
  end

  // All helpers start and end on a falling edge
  task automatic pulseStrobe(input logic isCtl, input logic [clkPkg::SEL_W-1:0] sel,
                             input logic [clkPkg::NIB_W-1:0] data);
    diagSel = sel;
    ebusData = data;
    ctlFunc = isCtl;
    ldFunc = ~isCtl;
    @(negedge MAIN_SOURCE);
    ctlFunc = 1'b0;
    ldFunc = 1'b0;
  endtask

  task automatic readField(input logic [clkPkg::SEL_W-1:0] sel,
                           output logic [clkPkg::READ_W-1:0] value);
    diagSel = sel;
    diagRead = 1'b1;
    #SAMPLE_DLY;
    value = readData;
    checkLevel("ebusDriving", ebusDriving, 1'b1);
    @(negedge MAIN_SOURCE);
    diagRead = 1'b0;
  endtask

  // Cycles are counted before the pulse shows up
  task automatic waitPulse(input string what, output int cycles);
    cycles = 0;
    #SAMPLE_DLY;
    while (!eboxClkEn) begin
      if (cycles >= PULSE_TIMEOUT) begin
        abortRun({"timed out waiting for an eboxClkEn pulse during ", what});
      end
      @(negedge MAIN_SOURCE);
      #SAMPLE_DLY;
      cycles++;
    end
    @(negedge MAIN_SOURCE);
  endtask

  task automatic countPulses(input int window, output int pulses);
    pulses = 0;
    repeat (window) begin
      #SAMPLE_DLY;
      if (eboxClkEn) pulses++;
      @(negedge MAIN_SOURCE);
    end
  endtask

  task automatic waitEbusResetLow(input string what);
    int cycles;
    cycles = 0;
    #SAMPLE_DLY;
    while (ebusReset) begin
      if (cycles >= EBUS_RESET_TIMEOUT) begin
        abortRun({"ebusReset stayed high too long after ", what});
      end
      @(negedge MAIN_SOURCE);
      #SAMPLE_DLY;
      cycles++;
    end
    @(negedge MAIN_SOURCE);
  endtask

  task automatic checkOutputs();
    #SAMPLE_DLY;
    checkLevel("mrReset", mrReset, expMr);
    checkLevel("sourceSel[1]", sourceSel[1], expSrc[1]);
    checkLevel("sourceSel[0]", sourceSel[0], expSrc[0]);
    checkLevel("rateSel[1]", rateSel[1], expRate[1]);
    checkLevel("rateSel[0]", rateSel[0], expRate[0]);
    checkLevel("crmDis", crmDis, expCrm);
    checkLevel("edpDis", edpDis, expEdp);
    checkLevel("ctlDis", ctlDis, expCtl);
    checkLevel("mboxCycleDis", mboxCycleDis, expMbox);
    checkLevel("errStopEn", errStopEn, expErr);
    // Bus released and readback quiet while diagRead is low
    checkLevel("ebusDriving", ebusDriving, 1'b0);
    checkRead("readData idle", readData, '0);
    @(negedge MAIN_SOURCE);
  endtask

  // Start, measure the tick spacing, then stop with a single step
  task automatic runAtRate(input logic [clkPkg::BURST_W-1:0] expGap);
    logic [clkPkg::READ_W-1:0] value;
    int gap;
    int pulses;
    pulseStrobe(1'b1, clkPkg::FN_START, '0);
    readField(clkPkg::RD_RUN, value);
    checkLevel("running", value[5], 1'b1);
    waitPulse("run", gap);
    waitPulse("run", gap);
    checkCount("eboxClkEn gap", clkPkg::BURST_W'(gap + 1), expGap);
    pulseStrobe(1'b1, clkPkg::FN_SINGLE_STEP, '0);
    countPulses(STEP_WINDOW, pulses);
    checkCount("eboxClkEn after stop", clkPkg::BURST_W'(pulses), 8'd1);
    readField(clkPkg::RD_RUN, value);
    checkLevel("running", value[5], 1'b0);
  endtask

  // Burst is done once burstZero reads back high
  task automatic runBurst(input logic [clkPkg::BURST_W-1:0] expected);
    int pulses;
    int cycles;
    int extra;
    bit done;
    pulses = 0;
    cycles = 0;
    done = 1'b0;
    pulseStrobe(1'b1, clkPkg::FN_BURST, '0);
    diagSel = clkPkg::RD_RUN;
    diagRead = 1'b1;
    while (!done) begin
      #SAMPLE_DLY;
      if (eboxClkEn) pulses++;
      if (readData[4]) begin
        done = 1'b1;
      end else if (cycles >= BURST_TIMEOUT) begin
        abortRun("burst did not finish before its timeout");
      end
      cycles++;
      @(negedge MAIN_SOURCE);
    end
    diagRead = 1'b0;
    countPulses(STEP_WINDOW, extra);
    checkCount("burst eboxClkEn pulses", clkPkg::BURST_W'(pulses), expected);
    checkCount("eboxClkEn after burst", clkPkg::BURST_W'(extra), 8'd0);
  endtask

  task automatic applyRow(input row_t r);
    logic [clkPkg::READ_W-1:0] value;
    int pulses;
    case (r.kind)
      ROW_CTL: begin
        pulseStrobe(1'b1, r.sel, r.data);
        if (r.sel == clkPkg::FN_CLR_RESET) expMr = 1'b0;
        else if (r.sel == clkPkg::FN_SET_RESET) expMr = 1'b1;
        checkOutputs();
      end
      ROW_LD: begin
        pulseStrobe(1'b0, r.sel, r.data);
        case (r.sel)
          clkPkg::LD_SRC_RATE: {expSrc, expRate} = r.data;
          clkPkg::LD_EBOX_DIS: {expCrm, expEdp, expCtl} = r.data[2:0];
          clkPkg::LD_MBOX_CTL: begin
            expMbox = r.data[3];
            expErr = r.data[0];
          end
          default: ;
        endcase
        checkOutputs();
      end
      ROW_READ: begin
        readField(r.sel, value);
        checkRead($sformatf("readData sel %0d", r.sel), value, r.expVal[5:0]);
      end
      ROW_STEP: begin
        pulseStrobe(1'b1, clkPkg::FN_SINGLE_STEP, '0);
        countPulses(STEP_WINDOW, pulses);
        checkCount("eboxClkEn single step", clkPkg::BURST_W'(pulses), r.expVal);
      end
      ROW_RUN:   runAtRate(r.expVal);
      ROW_BURST: runBurst(r.expVal);
      ROW_CONO: begin
        conoReset = 1'b1;
        @(negedge MAIN_SOURCE);
        conoReset = 1'b0;
        #SAMPLE_DLY;
        checkLevel("ebusReset", ebusReset, 1'b1);
        @(negedge MAIN_SOURCE);
        waitEbusResetLow("conoReset");
      end
      default: abortRun("unknown table row kind");
    endcase
  endtask

  function automatic void addRow(input rowKind_e kind, input logic [clkPkg::SEL_W-1:0] sel,
                                 input logic [clkPkg::NIB_W-1:0] data,
                                 input logic [clkPkg::BURST_W-1:0] expVal);
    row_t r;
    r.kind = kind;
    r.sel = sel;
    r.data = data;
    r.expVal = expVal;
    rows.push_back(r);
  endfunction

  // Expected readbacks worked out by hand from the field layout
  task automatic buildTable();
    // Master reset clear and set
    addRow(ROW_READ, clkPkg::RD_RESET, '0, 8'h20);
    addRow(ROW_CTL, clkPkg::FN_CLR_RESET, '0, '0);
    addRow(ROW_READ, clkPkg::RD_RESET, '0, 8'h00);
    addRow(ROW_CTL, clkPkg::FN_SET_RESET, '0, '0);
    addRow(ROW_READ, clkPkg::RD_RESET, '0, 8'h20);
    // Config loads with unused data bits set to catch leaks
    addRow(ROW_LD, clkPkg::LD_SRC_RATE, 4'b1001, '0);
    addRow(ROW_READ, clkPkg::RD_CONFIG, '0, 8'h24);
    addRow(ROW_LD, clkPkg::LD_EBOX_DIS, 4'b1101, '0);
    addRow(ROW_READ, clkPkg::RD_DISABLE, '0, 8'h28);
    addRow(ROW_LD, clkPkg::LD_MBOX_CTL, 4'b1001, '0);
    addRow(ROW_READ, clkPkg::RD_CONFIG, '0, 8'h27);
    // Load codes 0, 1 and 6 do nothing
    addRow(ROW_LD, 3'd0, 4'hF, '0);
    addRow(ROW_LD, 3'd1, 4'hF, '0);
    addRow(ROW_LD, clkPkg::LD_PAR_CHECK, 4'hF, '0);
    addRow(ROW_READ, clkPkg::RD_CONFIG, '0, 8'h27);
    addRow(ROW_READ, clkPkg::RD_DISABLE, '0, 8'h28);
    addRow(ROW_READ, clkPkg::RD_RUN, '0, 8'h10);
    addRow(ROW_READ, 3'd5, '0, 8'h00);
    addRow(ROW_LD, clkPkg::LD_EBOX_DIS, 4'b0010, '0);
    addRow(ROW_READ, clkPkg::RD_DISABLE, '0, 8'h10);
    addRow(ROW_LD, clkPkg::LD_MBOX_CTL, 4'b0110, '0);
    addRow(ROW_READ, clkPkg::RD_CONFIG, '0, 8'h24);
    // One step per rate, then free run per rate
    for (int r = 0; r < 4; r++) begin
      addRow(ROW_LD, clkPkg::LD_SRC_RATE, {2'b10, 2'(r)}, '0);
      addRow(ROW_STEP, clkPkg::FN_SINGLE_STEP, '0, 8'd1);
    end
    addRow(ROW_READ, clkPkg::RD_DISABLE, '0, 8'h10);
    for (int r = 0; r < 4; r++) begin
      addRow(ROW_LD, clkPkg::LD_SRC_RATE, {2'b10, 2'(r)}, '0);
      addRow(ROW_RUN, clkPkg::FN_START, '0, 8'(1 << r));
    end
    // Random burst at half rate, then an empty one
    burstLen = 8'($urandom % 255 + 1);
    addRow(ROW_LD, clkPkg::LD_SRC_RATE, 4'b1001, '0);
    addRow(ROW_LD, clkPkg::LD_BURST_LO, burstLen[3:0], '0);
    addRow(ROW_LD, clkPkg::LD_BURST_HI, burstLen[7:4], '0);
    addRow(ROW_READ, clkPkg::RD_RUN, '0, {4'b0000, burstLen[7:4]});
    addRow(ROW_READ, clkPkg::RD_RESET, '0, {4'b0010, burstLen[3:0]});
    addRow(ROW_BURST, clkPkg::FN_BURST, '0, burstLen);
    addRow(ROW_READ, clkPkg::RD_RUN, '0, 8'h10);
    addRow(ROW_BURST, clkPkg::FN_BURST, '0, 8'd0);
    // EBUS reset from CONO
    addRow(ROW_CONO, '0, '0, '0);
    addRow(ROW_READ, clkPkg::RD_RESET, '0, 8'h20);
  endtask

  initial begin
    seedVal = $urandom(SEED);
    CLK = 1'b1;
    ctlFunc = 1'b0;
    ldFunc = 1'b0;
    diagSel = '0;
    ebusData = '0;
    diagRead = 1'b0;
    conoReset = 1'b0;
    expMr = 1'b1;
    expSrc = '0;
    expRate = '0;
    {expCrm, expEdp, expCtl, expMbox, expErr} = '0;
    repeat (RESET_CYCLES) @(posedge MAIN_SOURCE);
    @(negedge MAIN_SOURCE);
    CLK = 1'b0;
    #SAMPLE_DLY;
    checkLevel("mrReset", mrReset, 1'b1);
    checkLevel("eboxClkEn", eboxClkEn, 1'b0);
    checkLevel("ebusReset", ebusReset, 1'b1);
    @(negedge MAIN_SOURCE);
    waitEbusResetLow("reset");
    buildTable();
    foreach (rows[i]) begin
      applyRow(rows[i]);
    end
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* clkControl.f */
+incdir+bench
common/clkPkg.sv
logic/functionDecoder.sv
logic/configRegs.sv
gating/burstCounter.sv
gating/clockGate.sv
logic/ebusResetTimer.sv
logic/diagReadMux.sv
logic/clkControl.sv
bench/clkControlTb.sv

/* Bender.yml */
package:
  name: clk_control

sources:
  - common/clkPkg.sv
  - logic/functionDecoder.sv
  - logic/configRegs.sv
  - gating/burstCounter.sv
  - gating/clockGate.sv
  - logic/ebusResetTimer.sv
  - logic/diagReadMux.sv
  - logic/clkControl.sv
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/clkControlTb.sv
